//--- src.f
+incdir+include
source/dac_pkg.sv
source/dac_apb_regs.sv
source/dac_tone_gen.sv
source/dac_data_format.sv
source/dac_top.sv
tests/dac_properties.sv
tests/dac_tb.sv

//--- Makefile
# Verilator flow for the DAC subsystem testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module dac_tb -f src.f

run: build
	./obj_dir/Vdac_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module dac_tb -f src.f

clean:
	rm -rf obj_dir $(LOG)

//--- tests/dac_tb.sv
// Testbench for the dual-channel DAC path, programming it over APB with bound checks
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_tb;

  logic                           dac_clk;
  logic                           rst_n;
  logic [`DAC_APB_ADDR_WIDTH-1:0] paddr;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [31:0]                    pwdata;
  logic [31:0]                    prdata;
  logic                           pready;
  logic                           pslverr;
  logic [`DAC_DATA_WIDTH-1:0]     dac_data_a;
  logic [`DAC_DATA_WIDTH-1:0]     dac_data_b;
  integer                         seed;

  dac_top i_dac_top (
    .dac_clk_i    (dac_clk),
    .rst_n_i      (rst_n),
    .paddr_i      (paddr),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .dac_data_a_o (dac_data_a),
    .dac_data_b_o (dac_data_b));

  initial begin
    dac_clk = 1'b0;
    forever #10 dac_clk = ~dac_clk;
  end

  // Stop at the first failed assertion in the bound checker
  always @(posedge dac_clk) begin
    if (i_dac_top.i_dac_properties.fail_count != 0) begin
      $display("Simulation FAILED");
      $fatal(1, "An assertion on the DAC path failed");
    end
  end

  // ************************************************************************
  // APB host tasks
  // ************************************************************************

  // A setup phase is followed by an access phase that lasts until pready is seen
  task automatic apb_transfer(input logic [`DAC_APB_ADDR_WIDTH-1:0] addr,
                              input logic write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
    int waits;
    waits = 0;
    @(posedge dac_clk);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge dac_clk);
    penable <= 1'b1;
    // Response is sampled mid-cycle, away from the clock edge
    @(negedge dac_clk);
    while (!pready) begin
      waits++;
      if (waits > 16) begin
        $display("Simulation FAILED");
        $fatal(1, "APB access to 0x%h never got pready", addr);
      end
      @(negedge dac_clk);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge dac_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [`DAC_APB_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] value);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(addr, 1'b1, value, rdata, slverr);
  endtask

  task automatic check_read(input logic [`DAC_APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(addr, 1'b0, 32'h0, rdata, slverr);
    if (rdata !== expected) begin
      $display("CHECK FAILED at %0t: read of 0x%h gave 0x%h, expected 0x%h",
               $time, addr, rdata, expected);
      $display("Simulation FAILED");
      $fatal(1, "Register readback mismatch");
    end
  endtask

  task automatic check_rejected(input logic [`DAC_APB_ADDR_WIDTH-1:0] addr,
                                input logic write);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(addr, write, 32'hFFFF_FFFF, rdata, slverr);
    if (slverr !== 1'b1) begin
      $display("CHECK FAILED at %0t: access to 0x%h was not rejected", $time, addr);
      $display("Simulation FAILED");
      $fatal(1, "Missing pslverr");
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge dac_clk);
  endtask

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  initial begin
    logic [31:0] word;
    seed    = 30614;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    run_cycles(4);
    rst_n <= 1'b1;
    run_cycles(6);

    // Only 14 word bits and 5 control bits of the register map are kept
    check_read(`DAC_REG_ID, `DAC_ID_VALUE);
    for (int i = 0; i < 4; i++) begin
      word = $random(seed);
      write_reg(`DAC_REG_CHAN_A, word);
      check_read(`DAC_REG_CHAN_A, word & 32'h0000_3FFF);
      word = $random(seed);
      write_reg(`DAC_REG_CHAN_B, word);
      check_read(`DAC_REG_CHAN_B, word & 32'h0000_3FFF);
      word = $random(seed);
      write_reg(`DAC_REG_CTRL, word);
      check_read(`DAC_REG_CTRL, word & 32'h0000_001F);
    end
    check_rejected(4'h2, 1'b0);
    check_rejected(4'h6, 1'b1);
    check_rejected(`DAC_REG_ID, 1'b1);
    check_read(`DAC_REG_ID, `DAC_ID_VALUE);

    // Patterns, muted channels and ramps in both codings
    for (int round = 0; round < 4; round++) begin
      write_reg(`DAC_REG_CHAN_A, $random(seed));
      write_reg(`DAC_REG_CHAN_B, $random(seed));
      write_reg(`DAC_REG_CTRL, 32'h03);
      run_cycles(8);
      write_reg(`DAC_REG_CTRL, 32'h13);
      run_cycles(8);
      write_reg(`DAC_REG_CTRL, 32'h01);
      run_cycles(6);
      write_reg(`DAC_REG_CTRL, 32'h1E);
      run_cycles(6);
      write_reg(`DAC_REG_CTRL, 32'h0F);
      run_cycles(20);
      write_reg(`DAC_REG_CTRL, 32'h1F);
      run_cycles(20);
      // Disable both ramps, then restart them from zero
      write_reg(`DAC_REG_CTRL, 32'h1C);
      run_cycles(4);
      write_reg(`DAC_REG_CTRL, 32'h1F);
      run_cycles(12);
    end

    run_cycles(4);
    // Assertions of the last edge have settled by the falling edge
    @(negedge dac_clk);
    if (i_dac_top.i_dac_properties.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "Assertion failures were counted");
    end
  end

endmodule

//--- tests/dac_properties.sv
// Bound checks of the DAC path covering APB response, reset state and converter words
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_properties import dac_pkg::*; (
  input logic                           dac_clk_i,
  input logic                           rst_n_i,
  input logic [`DAC_APB_ADDR_WIDTH-1:0] paddr_i,
  input logic                           psel_i,
  input logic                           penable_i,
  input logic                           pwrite_i,
  input logic                           pready_i,
  input logic                           pslverr_i,
  input dac_chan_cfg_t                  cfg_a_i,
  input dac_chan_cfg_t                  cfg_b_i,
  input logic                           offset_binary_i,
  input logic [`DAC_DATA_WIDTH-1:0]     dac_data_a_i,
  input logic [`DAC_DATA_WIDTH-1:0]     dac_data_b_i
);

  // Count of failed assertions
  int fail_count = 0;

  logic [32:0]                setup;
  logic [`DAC_DATA_WIDTH-1:0] flip;
  logic [`DAC_DATA_WIDTH-1:0] fixed_a;
  logic [`DAC_DATA_WIDTH-1:0] fixed_b;
  logic                       ramp_a;
  logic                       ramp_b;
  logic                       bad_addr;

  // Outputs are judged only while the whole setup of both channels holds still
  assign setup    = {offset_binary_i, cfg_a_i, cfg_b_i};
  // Offset binary only moves the sign bit, so mid-scale becomes 0x2000
  assign flip     = {offset_binary_i, {(`DAC_DATA_WIDTH-1){1'b0}}};
  // Word that a muted channel or a pattern channel must show
  assign fixed_a  = cfg_a_i.enable ? (cfg_a_i.word.pattern ^ flip) : flip;
  assign fixed_b  = cfg_b_i.enable ? (cfg_b_i.word.pattern ^ flip) : flip;
  assign ramp_a   = cfg_a_i.enable && cfg_a_i.ramp_mode;
  assign ramp_b   = cfg_b_i.enable && cfg_b_i.ramp_mode;
  assign bad_addr = !(paddr_i inside {`DAC_REG_CTRL, `DAC_REG_CHAN_A, `DAC_REG_CHAN_B,
                                      `DAC_REG_ID});

  // ************************************************************************
  // APB response and reset state
  // ************************************************************************

  assert property (@(posedge dac_clk_i) pready_i)
    else begin
      fail_count++;
      $error("pready dropped low");
    end
  // Errors come only in the access phase for unmapped offsets or a write to the ID word
  assert property (@(posedge dac_clk_i) disable iff (!rst_n_i)
    pslverr_i == (psel_i && penable_i && (bad_addr || (pwrite_i && paddr_i == `DAC_REG_ID))))
    else begin
      fail_count++;
      $error("pslverr does not match the access");
    end
  assert property (@(posedge dac_clk_i)
    !rst_n_i |-> (dac_data_a_i == '0 && dac_data_b_i == '0 && !pslverr_i))
    else begin
      fail_count++;
      $error("outputs not cleared in reset");
    end

  // ************************************************************************
  // Converter words under a stable setup
  // ************************************************************************

  // Two stable cycles cover the tone generator and the formatter stage
  assert property (@(posedge dac_clk_i) disable iff (!rst_n_i)
    (setup == $past(setup) && setup == $past(setup, 2)) |->
      (ramp_a || dac_data_a_i == fixed_a) && (ramp_b || dac_data_b_i == fixed_b))
    else begin
      fail_count++;
      $error("muted or pattern word is wrong");
    end
  // A ramp step needs the previous word made under the same setup as well
  assert property (@(posedge dac_clk_i) disable iff (!rst_n_i)
    (setup == $past(setup) && setup == $past(setup, 2) && setup == $past(setup, 3)) |->
      (!ramp_a || dac_data_a_i - $past(dac_data_a_i) == cfg_a_i.word.increment) &&
      (!ramp_b || dac_data_b_i - $past(dac_data_b_i) == cfg_b_i.word.increment))
    else begin
      fail_count++;
      $error("ramp step differs from the increment");
    end
  // Enabled three samples back but not four, so this is the first ramp word
  assert property (@(posedge dac_clk_i) disable iff (!rst_n_i)
    (setup == $past(setup) && setup == $past(setup, 2)) |->
      (!(ramp_a && !$past(cfg_a_i.enable, 3)) || dac_data_a_i == (cfg_a_i.word ^ flip)) &&
      (!(ramp_b && !$past(cfg_b_i.enable, 3)) || dac_data_b_i == (cfg_b_i.word ^ flip)))
    else begin
      fail_count++;
      $error("ramp did not restart at one increment");
    end

endmodule

bind dac_top dac_properties i_dac_properties (
  .dac_clk_i, .rst_n_i, .paddr_i, .psel_i, .penable_i, .pwrite_i,
  .pready_i        (pready_o),
  .pslverr_i       (pslverr_o),
  .cfg_a_i         (cfg_a),
  .cfg_b_i         (cfg_b),
  .offset_binary_i (offset_binary),
  .dac_data_a_i    (dac_data_a_o),
  .dac_data_b_i    (dac_data_b_o));

//--- source/dac_top.sv
// Top level of the dual-channel DAC path joining APB registers, tone sources and formatter
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_top import dac_pkg::*; (
  input  logic                           dac_clk_i,
  input  logic                           rst_n_i,

  // APB host port
  input  logic [`DAC_APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [31:0]                    pwdata_i,
  output logic [31:0]                    prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,

  // Converter data pins
  output logic [`DAC_DATA_WIDTH-1:0]     dac_data_a_o,
  output logic [`DAC_DATA_WIDTH-1:0]     dac_data_b_o
);

  // internal signals

  dac_chan_cfg_t cfg_a;
  dac_chan_cfg_t cfg_b;
  logic          offset_binary;
  dac_sample_t   samples;

  // ***********************************************************************
  // Register block, the input side
  // ***********************************************************************

  dac_apb_regs i_apb_regs (
    .dac_clk_i       (dac_clk_i),
    .rst_n_i         (rst_n_i),
    .paddr_i         (paddr_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .pwdata_i        (pwdata_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pslverr_o       (pslverr_o),
    .cfg_a_o         (cfg_a),
    .cfg_b_o         (cfg_b),
    .offset_binary_o (offset_binary));

  // ***********************************************************************
  // Tone sources, one per channel
  // ***********************************************************************

  dac_tone_gen i_tone_a (
    .dac_clk_i (dac_clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_i     (cfg_a),
    .sample_o  (samples.sample_a));

  dac_tone_gen i_tone_b (
    .dac_clk_i (dac_clk_i),
    .rst_n_i   (rst_n_i),
    .cfg_i     (cfg_b),
    .sample_o  (samples.sample_b));

  // Formatter takes the raw enables and aligns them internally
  dac_data_format i_data_format (
    .dac_clk_i       (dac_clk_i),
    .rst_n_i         (rst_n_i),
    .samples_i       (samples),
    .enable_a_i      (cfg_a.enable),
    .enable_b_i      (cfg_b.enable),
    .offset_binary_i (offset_binary),
    .dac_data_a_o    (dac_data_a_o),
    .dac_data_b_o    (dac_data_b_o));

endmodule

//--- source/dac_data_format.sv
// DAC output formatter that mutes, recodes and registers both channel words for the pins
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_data_format import dac_pkg::*; (
  input  logic                       dac_clk_i,
  input  logic                       rst_n_i,
  input  dac_sample_t                samples_i,
  input  logic                       enable_a_i,
  input  logic                       enable_b_i,
  input  logic                       offset_binary_i,
  output logic [`DAC_DATA_WIDTH-1:0] dac_data_a_o,
  output logic [`DAC_DATA_WIDTH-1:0] dac_data_b_o
);

  // Control delayed by one stage so it lines up with the tone generator output
  logic en_a_q;
  logic en_b_q;
  logic offset_bin_q;

  // Final words as seen by the converter
  logic [`DAC_DATA_WIDTH-1:0] data_a_q;
  logic [`DAC_DATA_WIDTH-1:0] data_b_q;

  // Mid-scale is zero in two's complement; offset binary flips the sign bit
  function automatic logic [`DAC_DATA_WIDTH-1:0] recode(
    input logic signed [`DAC_DATA_WIDTH-1:0] sample,
    input logic                              enable,
    input logic                              offset_bin
  );
    logic [`DAC_DATA_WIDTH-1:0] muted;
    muted = enable ? sample : '0;
    return {muted[`DAC_DATA_WIDTH-1] ^ offset_bin, muted[`DAC_DATA_WIDTH-2:0]};
  endfunction

  // ***********************************************************************
  // Control alignment and output registers
  // ***********************************************************************

  // Any configuration change reaches the pins two cycles after it is written
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_a_q       <= 1'b0;
      en_b_q       <= 1'b0;
      offset_bin_q <= 1'b0;
      data_a_q     <= '0;
      data_b_q     <= '0;
    end else begin
      en_a_q       <= enable_a_i;
      en_b_q       <= enable_b_i;
      offset_bin_q <= offset_binary_i;
      data_a_q     <= recode(samples_i.sample_a, en_a_q, offset_bin_q);
      data_b_q     <= recode(samples_i.sample_b, en_b_q, offset_bin_q);
    end
  end

  // Straight from flops so the converter sees a clean edge
  assign dac_data_a_o = data_a_q;
  assign dac_data_b_o = data_b_q;

endmodule

//--- source/dac_tone_gen.sv
// Single DAC channel tone source giving a fixed pattern or an increment-driven ramp
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_tone_gen import dac_pkg::*; (
  input  logic                              dac_clk_i,
  input  logic                              rst_n_i,
  input  dac_chan_cfg_t                     cfg_i,
  output logic signed [`DAC_DATA_WIDTH-1:0] sample_o
);

  // Phase accumulator of the ramp, wraps modulo 2 to the data width
  logic        [`DAC_DATA_WIDTH-1:0] phase_q;
  logic        [`DAC_DATA_WIDTH-1:0] phase_nxt;

  // Registered sample toward the formatter
  logic signed [`DAC_DATA_WIDTH-1:0] sample_q;

  // ***********************************************************************
  // Ramp arithmetic
  // ***********************************************************************

  // The word is read through its unsigned view as a step size
  // Overflow drops off the top, which gives the modulo wrap
  assign phase_nxt = phase_q + cfg_i.word.increment;

  // ***********************************************************************
  // Sample register
  // ***********************************************************************

  // One cycle from configuration to sample in every mode
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q  <= '0;
      sample_q <= '0;
    end else if (!cfg_i.enable) begin
      // Disabled channel, so re-enabling restarts the ramp at zero
      phase_q  <= '0;
      sample_q <= '0;
    end else if (cfg_i.ramp_mode) begin
      // First sample after enable equals one increment
      phase_q  <= phase_nxt;
      sample_q <= $signed(phase_nxt);
    end else begin
      // Pattern mode reads the signed view, and the phase waits at zero
      phase_q  <= '0;
      sample_q <= cfg_i.word.pattern;
    end
  end

  assign sample_o = sample_q;

endmodule

//--- source/dac_apb_regs.sv
// APB register block holding DAC control and channel words, with readback and error flag
`timescale 1ns/100ps
`include "dac_defines.svh"

module dac_apb_regs import dac_pkg::*; (
  input  logic                           dac_clk_i,
  input  logic                           rst_n_i,

  // APB slave port
  input  logic [`DAC_APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [31:0]                    pwdata_i,
  output logic [31:0]                    prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,

  // Channel setup toward the tone generators and the formatter
  output dac_chan_cfg_t                  cfg_a_o,
  output dac_chan_cfg_t                  cfg_b_o,
  output logic                           offset_binary_o
);

  // Stored register contents, only implemented bits are kept
  logic [`DAC_CTRL_WIDTH-1:0] ctrl_q;
  logic [`DAC_DATA_WIDTH-1:0] chan_a_q;
  logic [`DAC_DATA_WIDTH-1:0] chan_b_q;

  // Address decode and access qualifiers
  logic access;
  logic sel_ctrl;
  logic sel_chan_a;
  logic sel_chan_b;
  logic sel_id;
  logic addr_hit;
  logic wr_en;

  // ***********************************************************************
  // Address decode and error response
  // ***********************************************************************

  // The access phase is the second cycle of a transfer
  assign access     = psel_i & penable_i;

  assign sel_ctrl   = (paddr_i == `DAC_REG_CTRL);
  assign sel_chan_a = (paddr_i == `DAC_REG_CHAN_A);
  assign sel_chan_b = (paddr_i == `DAC_REG_CHAN_B);
  assign sel_id     = (paddr_i == `DAC_REG_ID);
  assign addr_hit   = sel_ctrl | sel_chan_a | sel_chan_b | sel_id;

  // Unmapped offsets and writes to the ID word are rejected
  assign pslverr_o  = access & (~addr_hit | (pwrite_i & sel_id));

  // No wait states, every transfer ends in its first access cycle
  assign pready_o   = 1'b1;

  // A rejected write leaves all registers untouched
  assign wr_en      = access & pwrite_i & ~pslverr_o;

  // ***********************************************************************
  // Register storage
  // ***********************************************************************

  // Writes land on the edge that closes the access phase
  always_ff @(posedge dac_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q   <= '0;
      chan_a_q <= '0;
      chan_b_q <= '0;
    end else if (wr_en) begin
      if (sel_ctrl) begin
        ctrl_q <= pwdata_i[`DAC_CTRL_WIDTH-1:0];
      end
      if (sel_chan_a) begin
        chan_a_q <= pwdata_i[`DAC_DATA_WIDTH-1:0];
      end
      if (sel_chan_b) begin
        chan_b_q <= pwdata_i[`DAC_DATA_WIDTH-1:0];
      end
    end
  end

  // Readback is combinational and zero-extends each register
  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      prdata_o = {{(32-`DAC_CTRL_WIDTH){1'b0}}, ctrl_q};
    end else if (sel_chan_a) begin
      prdata_o = {{(32-`DAC_DATA_WIDTH){1'b0}}, chan_a_q};
    end else if (sel_chan_b) begin
      prdata_o = {{(32-`DAC_DATA_WIDTH){1'b0}}, chan_b_q};
    end else if (sel_id) begin
      prdata_o = `DAC_ID_VALUE;
    end
  end

  // ***********************************************************************
  // Configuration outputs
  // ***********************************************************************

  // Each channel gets its enable, its mode and its own word
  assign cfg_a_o.enable    = ctrl_q[`DAC_CTRL_EN_A];
  assign cfg_a_o.ramp_mode = ctrl_q[`DAC_CTRL_RAMP_A];
  assign cfg_a_o.word      = chan_a_q;

  assign cfg_b_o.enable    = ctrl_q[`DAC_CTRL_EN_B];
  assign cfg_b_o.ramp_mode = ctrl_q[`DAC_CTRL_RAMP_B];
  assign cfg_b_o.word      = chan_b_q;

  assign offset_binary_o   = ctrl_q[`DAC_CTRL_OFFSET_BIN];

endmodule

//--- source/dac_pkg.sv
// Shared types of the DAC subsystem for channel words, channel setup and sample pairs
`include "dac_defines.svh"

package dac_pkg;

  // ***********************************************************************
  // Channel word
  // ***********************************************************************

  // The same programmed word means two things depending on the channel mode
  // In pattern mode it is the signed sample sent to the converter
  // In ramp mode it is the unsigned step added to the phase every clock
  typedef union packed {
    logic signed [`DAC_DATA_WIDTH-1:0] pattern;
    logic        [`DAC_DATA_WIDTH-1:0] increment;
  } dac_chan_word_u;

  // ***********************************************************************
  // Channel configuration and sample pair
  // ***********************************************************************

  // Per-channel setup as held by the register block, 16 bits in total
  typedef struct packed {
    logic           enable;
    logic           ramp_mode;
    dac_chan_word_u word;
  } dac_chan_cfg_t;

  // Both channel samples in two's complement, 28 bits in total
  // Channel A sits in the upper half
  typedef struct packed {
    logic signed [`DAC_DATA_WIDTH-1:0] sample_a;
    logic signed [`DAC_DATA_WIDTH-1:0] sample_b;
  } dac_sample_t;

endpackage

//--- include/dac_defines.svh
// Dual-channel DAC subsystem constants for sample width, APB map and identification
`ifndef DAC_DEFINES_SVH
`define DAC_DEFINES_SVH

// Width of one converter sample
`define DAC_DATA_WIDTH      14

// APB address width and register offsets
`define DAC_APB_ADDR_WIDTH  4
`define DAC_REG_CTRL        4'h0
`define DAC_REG_CHAN_A      4'h4
`define DAC_REG_CHAN_B      4'h8
`define DAC_REG_ID          4'hC

// Control register layout, five implemented bits
`define DAC_CTRL_WIDTH      5
`define DAC_CTRL_EN_A       0
`define DAC_CTRL_EN_B       1
`define DAC_CTRL_RAMP_A     2
`define DAC_CTRL_RAMP_B     3
`define DAC_CTRL_OFFSET_BIN 4

// Constant returned by the read-only identification register
`define DAC_ID_VALUE        32'h0DAC_0214

`endif
